// File: Makefile
# Verilator build and run of the host glue testbench

TOP = tb_a2_host_glue

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build folder"

test:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

// File: hw/a2_glue_pkg.sv
// Shared widths, memory depths and HDD FSM encoding; the main RAM depth is not a power of two, so addresses above it are unmapped
package a2_glue_pkg;

	// ==================================================
	// Widths
	// ==================================================

	// RAM data path is byte wide
	localparam int BYTE_W = 8;
	// Core address covers the 192 KB main bank
	localparam int RAM_ADDR_W = 18;
	// Aux bank only sees the low address bits
	localparam int AUX_ADDR_W = 16;
	// One analog axis or paddle sample
	localparam int AXIS_W = 8;
	// Fire pair plus two direction pairs
	localparam int JOY_DIG_W = 6;
	localparam int LBA_W = 32;
	localparam int IMG_SIZE_W = 64;

	// ==================================================
	// Memory sizes
	// ==================================================

	localparam int MAIN_RAM_BYTES = 196608;
	localparam int AUX_RAM_BYTES = 65536;

	// ==================================================
	// Types
	// ==================================================

	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
	typedef logic [AUX_ADDR_W-1:0] aux_addr_t;
	// Aux byte high, main byte low
	typedef logic [2*BYTE_W-1:0] ram_word_t;
	typedef logic [AXIS_W-1:0] axis_t;
	// X in the high byte, Y in the low byte
	typedef logic [2*AXIS_W-1:0] joy_analog_t;
	// Bits 5:4 fire, 3:2 vertical, 1:0 horizontal
	typedef logic [JOY_DIG_W-1:0] joy_digital_t;
	typedef logic [LBA_W-1:0] sector_lba_t;
	typedef logic [IMG_SIZE_W-1:0] img_size_t;

	// HDD sequencer states
	typedef enum logic [0:0] {
		HDD_IDLE = 1'b0,
		HDD_XFER = 1'b1
	} hdd_state_t;

endpackage

// File: hw/a2_host_glue.sv
// Apple II host glue top in clk_sys; option inputs are active high by effect and the LBA passes through unregistered
`timescale 1ns/1ns

module a2_host_glue (
	input  logic                      clk_sys,
	input  logic                      dd_reset,

	// Joystick and paddle
	input  logic                      analog_swap,
	input  logic                      paddle_on_x,
	input  logic                      paddle_on_y,
	input  a2_glue_pkg::axis_t        paddle_raw,
	input  a2_glue_pkg::joy_analog_t  joy_analog_raw,
	input  a2_glue_pkg::joy_digital_t joy_digital_raw,
	output a2_glue_pkg::joy_analog_t  joy_analog,
	output a2_glue_pkg::joy_digital_t joy_digital,

	// Hard disk
	input  logic                      hdd_read,
	input  logic                      hdd_write,
	input  a2_glue_pkg::sector_lba_t  hdd_lba_in,
	input  logic                      sd_ack,
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  a2_glue_pkg::img_size_t    img_size,
	output a2_glue_pkg::sector_lba_t  hdd_lba,
	output logic                      sd_rd,
	output logic                      sd_wr,
	output logic                      cpu_wait,
	output logic                      hdd_mounted,
	output logic                      hdd_protect,

	// Core RAM
	input  a2_glue_pkg::ram_addr_t    ram_addr,
	input  a2_glue_pkg::byte_t        ram_din,
	input  logic                      ram_we,
	input  logic                      ram_aux,
	output a2_glue_pkg::ram_word_t    ram_dout
);

	// ==================================================
	// Joystick pipeline
	// ==================================================

	// Carries stage one registers into stage two
	joy_stage_if stage_bus ();

	joy_axis_map u_axis_map (
		.clk_sys         (clk_sys),
		.dd_reset        (dd_reset),
		.analog_swap     (analog_swap),
		.paddle_on_x     (paddle_on_x),
		.paddle_on_y     (paddle_on_y),
		.paddle_raw      (paddle_raw),
		.joy_analog_raw  (joy_analog_raw),
		.joy_digital_raw (joy_digital_raw),
		.stage           (stage_bus.producer)
	);

	joy_button_gate u_button_gate (
		.clk_sys     (clk_sys),
		.dd_reset    (dd_reset),
		.stage       (stage_bus.consumer),
		.joy_analog  (joy_analog),
		.joy_digital (joy_digital)
	);

	// ==================================================
	// Hard disk sequencer
	// ==================================================

	hdd_request_seq u_hdd_seq (
		.clk_sys      (clk_sys),
		.dd_reset     (dd_reset),
		.hdd_read     (hdd_read),
		.hdd_write    (hdd_write),
		.sd_ack       (sd_ack),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.cpu_wait     (cpu_wait),
		.hdd_mounted  (hdd_mounted),
		.hdd_protect  (hdd_protect)
	);

	// Sector number goes straight from core to host
	assign hdd_lba = hdd_lba_in;

	// ==================================================
	// RAM
	// ==================================================

	apple_ram_banks u_ram (
		.clk_sys  (clk_sys),
		.ram_addr (ram_addr),
		.ram_din  (ram_din),
		.ram_we   (ram_we),
		.ram_aux  (ram_aux),
		.ram_dout (ram_dout)
	);

endmodule

// File: hw/apple_ram_banks.sv
// Main and aux byte RAMs with one-cycle read; main addresses past 192 KB are unmapped and contents are never cleared
`timescale 1ns/1ns

module apple_ram_banks (
	input  logic                   clk_sys,
	input  a2_glue_pkg::ram_addr_t ram_addr,
	input  a2_glue_pkg::byte_t     ram_din,
	input  logic                   ram_we,
	input  logic                   ram_aux,
	output a2_glue_pkg::ram_word_t ram_dout
);

	localparam int BW = a2_glue_pkg::BYTE_W;

	// Memory arrays
	a2_glue_pkg::byte_t main_mem [a2_glue_pkg::MAIN_RAM_BYTES];
	a2_glue_pkg::byte_t aux_mem [a2_glue_pkg::AUX_RAM_BYTES];

	a2_glue_pkg::aux_addr_t aux_addr;
	logic                   main_we;
	logic                   aux_we;

	// Aux bank only decodes the low 16 bits
	assign aux_addr = ram_addr[a2_glue_pkg::AUX_ADDR_W-1:0];

	// Bank select for writes
	assign main_we = ram_we & ~ram_aux;
	assign aux_we  = ram_we & ram_aux;

	// ==================================================
	// Main bank, low byte of the read word
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (main_we) begin
			main_mem[ram_addr] <= ram_din;
			// Write returns the new byte
			ram_dout[BW-1:0] <= ram_din;
		end else begin
			ram_dout[BW-1:0] <= main_mem[ram_addr];
		end
	end

	// ==================================================
	// Aux bank, high byte of the read word
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (aux_we) begin
			aux_mem[aux_addr] <= ram_din;
			ram_dout[2*BW-1:BW] <= ram_din;
		end else begin
			ram_dout[2*BW-1:BW] <= aux_mem[aux_addr];
		end
	end

endmodule

// File: hw/hdd_request_seq.sv
// HDD sector request FSM; a request pulse coinciding with the ack rise is dropped, and mount flags survive reset
`timescale 1ns/1ns

module hdd_request_seq (
	input  logic                   clk_sys,
	input  logic                   dd_reset,
	input  logic                   hdd_read,
	input  logic                   hdd_write,
	input  logic                   sd_ack,
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	input  a2_glue_pkg::img_size_t img_size,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output logic                   cpu_wait,
	output logic                   hdd_mounted,
	output logic                   hdd_protect
);

	a2_glue_pkg::hdd_state_t state;
	logic                    ack_q;
	logic                    ack_rise;
	logic                    ack_fall;
	logic                    read_pending;
	logic                    write_pending;
	// Powers up unmounted, only a mount event changes it
	logic                    mounted_q = 1'b0;

	// ==================================================
	// Acknowledge edges
	// ==================================================

	assign ack_rise = sd_ack & ~ack_q;
	assign ack_fall = ~sd_ack & ack_q;

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= sd_ack;
		end
	end

	// ==================================================
	// Request latch and FSM
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			state         <= a2_glue_pkg::HDD_IDLE;
			read_pending  <= 1'b0;
			write_pending <= 1'b0;
			sd_rd         <= 1'b0;
			sd_wr         <= 1'b0;
			cpu_wait      <= 1'b0;
		end else begin
			// Pulses accumulate until the host takes the sector
			read_pending  <= read_pending | hdd_read;
			write_pending <= write_pending | hdd_write;
			case (state)
				a2_glue_pkg::HDD_IDLE: begin
					if (read_pending | write_pending) begin
						state    <= a2_glue_pkg::HDD_XFER;
						sd_rd    <= read_pending;
						sd_wr    <= write_pending;
						// CPU stalls until the host finishes
						cpu_wait <= 1'b1;
					end
				end
				a2_glue_pkg::HDD_XFER: begin
					if (ack_rise) begin
						// Host has the request, clear it here
						read_pending  <= 1'b0;
						write_pending <= 1'b0;
						sd_rd         <= 1'b0;
						sd_wr         <= 1'b0;
					end else if (ack_fall) begin
						state    <= a2_glue_pkg::HDD_IDLE;
						cpu_wait <= 1'b0;
					end
				end
				default: begin
					state <= a2_glue_pkg::HDD_IDLE;
				end
			endcase
		end
	end

	// ==================================================
	// Mount capture
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (img_mounted) begin
			// Zero size means the image was ejected
			mounted_q   <= (img_size != '0);
			hdd_protect <= img_readonly;
		end
	end

	assign hdd_mounted = mounted_q;

endmodule

// File: hw/joy_axis_map.sv
// Joystick stage one; paddle is offset binary from the host and option inputs are sampled with the data each clock
`timescale 1ns/1ns

module joy_axis_map (
	input  logic                      clk_sys,
	input  logic                      dd_reset,
	input  logic                      analog_swap,
	input  logic                      paddle_on_x,
	input  logic                      paddle_on_y,
	input  a2_glue_pkg::axis_t        paddle_raw,
	input  a2_glue_pkg::joy_analog_t  joy_analog_raw,
	input  a2_glue_pkg::joy_digital_t joy_digital_raw,
	joy_stage_if.producer             stage
);

	localparam int AW = a2_glue_pkg::AXIS_W;

	a2_glue_pkg::axis_t       paddle_conv;
	a2_glue_pkg::joy_analog_t swapped;
	a2_glue_pkg::axis_t       map_x;
	a2_glue_pkg::axis_t       map_y;

	// ==================================================
	// Combinational mapping
	// ==================================================

	// Flip the sign bit to turn the paddle into the core's centered range
	assign paddle_conv = {~paddle_raw[AW-1], paddle_raw[AW-2:0]};

	// Exchange X and Y bytes on request
	assign swapped = analog_swap ? {joy_analog_raw[AW-1:0], joy_analog_raw[2*AW-1:AW]}
		: joy_analog_raw;

	// Paddle may stand in for either axis independently
	assign map_x = paddle_on_x ? paddle_conv : swapped[2*AW-1:AW];
	assign map_y = paddle_on_y ? paddle_conv : swapped[AW-1:0];

	// ==================================================
	// Stage register
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			stage.analog    <= '0;
			stage.swapped_x <= '0;
			stage.swapped_y <= '0;
			stage.digital   <= '0;
		end else begin
			stage.analog    <= {map_x, map_y};
			// Raw swapped axes feed the direction gating, never the paddle
			stage.swapped_x <= swapped[2*AW-1:AW];
			stage.swapped_y <= swapped[AW-1:0];
			stage.digital   <= joy_digital_raw;
		end
	end

endmodule

// File: hw/joy_button_gate.sv
// Joystick stage two; directions are suppressed whenever the matching analog axis is off zero
`timescale 1ns/1ns

module joy_button_gate (
	input  logic                      clk_sys,
	input  logic                      dd_reset,
	joy_stage_if.consumer             stage,
	output a2_glue_pkg::joy_analog_t  joy_analog,
	output a2_glue_pkg::joy_digital_t joy_digital
);

	logic                      x_centered;
	logic                      y_centered;
	a2_glue_pkg::joy_digital_t gated;

	// ==================================================
	// Direction gating
	// ==================================================

	// Axis at zero means the analog stick is not deflected
	assign x_centered = (stage.swapped_x == '0);
	assign y_centered = (stage.swapped_y == '0);

	// Fire buttons always pass
	assign gated[5:4] = stage.digital[5:4];
	// Vertical pair follows the Y axis
	assign gated[3:2] = stage.digital[3:2] & {2{y_centered}};
	// Horizontal pair follows the X axis
	assign gated[1:0] = stage.digital[1:0] & {2{x_centered}};

	// ==================================================
	// Output register
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			joy_analog  <= '0;
			joy_digital <= '0;
		end else begin
			joy_analog  <= stage.analog;
			joy_digital <= gated;
		end
	end

endmodule

// File: hw/joy_stage_if.sv
// Joystick stage-one results; registered every clock with no valid, so the consumer samples unconditionally
`timescale 1ns/1ns

interface joy_stage_if;

	// Analog pair after paddle substitution
	a2_glue_pkg::joy_analog_t analog;
	// Raw axes after the optional byte exchange
	a2_glue_pkg::axis_t swapped_x;
	a2_glue_pkg::axis_t swapped_y;
	// Digital buttons and directions, not yet gated
	a2_glue_pkg::joy_digital_t digital;

	// Stage one side
	modport producer (
		output analog,
		output swapped_x,
		output swapped_y,
		output digital
	);

	// Stage two side
	modport consumer (
		input analog,
		input swapped_x,
		input swapped_y,
		input digital
	);

endinterface

// File: sim.f
hw/a2_glue_pkg.sv
hw/joy_stage_if.sv
hw/joy_axis_map.sv
hw/joy_button_gate.sv
hw/hdd_request_seq.sv
hw/apple_ram_banks.sv
hw/a2_host_glue.sv
test/a2_host_glue_checker.sv
test/tb_a2_host_glue.sv

// File: test/a2_host_glue_checker.sv
// Sequencer assertions bound into hdd_request_seq; they assume no read pulse is issued while a write is pending
`timescale 1ns/1ns

module a2_host_glue_checker (
	input logic clk_sys,
	input logic dd_reset,
	input logic hdd_read,
	input logic hdd_write,
	input logic write_pending,
	input logic sd_rd,
	input logic sd_wr,
	input logic cpu_wait
);

	// Read pulse seen with no write anywhere in flight
	logic lone_read_q;
	// Count of failed properties
	int   assert_fails = 0;

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			lone_read_q <= 1'b0;
		end else begin
			lone_read_q <= hdd_read & ~hdd_write & ~write_pending;
		end
	end

	// ==================================================
	// Properties
	// ==================================================

	// Reset leaves every request output low
	reset_clears: assert property (@(posedge clk_sys)
		dd_reset |=> (!sd_rd && !sd_wr && !cpu_wait))
		else begin
			$error("request outputs still high after reset");
			assert_fails++;
		end

	// CPU is held whenever a request is up
	request_holds_cpu: assert property (@(posedge clk_sys) disable iff (dd_reset)
		(sd_rd || sd_wr) |-> cpu_wait)
		else begin
			$error("sd request without cpu_wait");
			assert_fails++;
		end

	// A lone read must not raise both requests
	read_only_request: assert property (@(posedge clk_sys) disable iff (dd_reset)
		(lone_read_q && !hdd_write && !write_pending) |=> !(sd_rd && sd_wr))
		else begin
			$error("read pulse raised sd_rd and sd_wr together");
			assert_fails++;
		end

endmodule

bind hdd_request_seq a2_host_glue_checker u_checker (
	.clk_sys       (clk_sys),
	.dd_reset      (dd_reset),
	.hdd_read      (hdd_read),
	.hdd_write     (hdd_write),
	.write_pending (write_pending),
	.sd_rd         (sd_rd),
	.sd_wr         (sd_wr),
	.cpu_wait      (cpu_wait)
);

// File: test/tb_a2_host_glue.sv
// Self-checking testbench for the host glue; RAM lanes are only compared at addresses written earlier in the run
`timescale 1ns/1ns

module tb_a2_host_glue;

	// ==================================================
	// Run limits
	// ==================================================

	localparam int JOY_SAMPLES = 200;
	localparam int RAM_ROUNDS = 120;
	// Reset, joystick, RAM, HDD read, HDD queued, mount
	localparam int CYCLE_BUDGET = 12 + (JOY_SAMPLES + 4) + 2 * RAM_ROUNDS + 30 + 60 + 10;
	localparam int TIMEOUT_CYCLES = 2 * CYCLE_BUDGET;

	logic                      clk_sys;
	logic                      dd_reset;
	logic                      analog_swap;
	logic                      paddle_on_x;
	logic                      paddle_on_y;
	a2_glue_pkg::axis_t        paddle_raw;
	a2_glue_pkg::joy_analog_t  joy_analog_raw;
	a2_glue_pkg::joy_digital_t joy_digital_raw;
	a2_glue_pkg::joy_analog_t  joy_analog;
	a2_glue_pkg::joy_digital_t joy_digital;
	logic                      hdd_read;
	logic                      hdd_write;
	a2_glue_pkg::sector_lba_t  hdd_lba_in;
	logic                      sd_ack;
	logic                      img_mounted;
	logic                      img_readonly;
	a2_glue_pkg::img_size_t    img_size;
	a2_glue_pkg::sector_lba_t  hdd_lba;
	logic                      sd_rd;
	logic                      sd_wr;
	logic                      cpu_wait;
	logic                      hdd_mounted;
	logic                      hdd_protect;
	a2_glue_pkg::ram_addr_t    ram_addr;
	a2_glue_pkg::byte_t        ram_din;
	logic                      ram_we;
	logic                      ram_aux;
	a2_glue_pkg::ram_word_t    ram_dout;

	integer seed = 32'h1309_95bf;
	int     cycle_cnt = 0;
	int     err_cnt = 0;
	int     check_cnt = 0;
	int     test_cnt = 0;
	int     test_errs = 0;

	// Expected joystick outputs, stamped with the cycle their inputs went in
	int                        joy_stamp_q [$];
	a2_glue_pkg::joy_analog_t  joy_exp_analog_q [$];
	a2_glue_pkg::joy_digital_t joy_exp_digital_q [$];
	a2_glue_pkg::joy_analog_t  exp_analog;
	a2_glue_pkg::joy_digital_t exp_digital;

	// RAM models, keyed by bank address
	a2_glue_pkg::byte_t main_model [int];
	a2_glue_pkg::byte_t aux_model [int];

	a2_host_glue uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// ==================================================
	// Reference model
	// ==================================================

	function automatic a2_glue_pkg::joy_analog_t ref_joy_analog(input logic swap,
		input logic pad_x, input logic pad_y, input a2_glue_pkg::axis_t paddle,
		input a2_glue_pkg::joy_analog_t raw);
		a2_glue_pkg::axis_t ax;
		a2_glue_pkg::axis_t ay;
		ax = swap ? raw[7:0] : raw[15:8];
		ay = swap ? raw[15:8] : raw[7:0];
		// Paddle with its top bit inverted replaces the chosen axis
		if (pad_x)
			ax = paddle ^ 8'h80;
		if (pad_y)
			ay = paddle ^ 8'h80;
		return {ax, ay};
	endfunction

	function automatic a2_glue_pkg::joy_digital_t ref_joy_digital(input logic swap,
		input a2_glue_pkg::joy_analog_t raw, input a2_glue_pkg::joy_digital_t dig);
		a2_glue_pkg::axis_t        sx;
		a2_glue_pkg::axis_t        sy;
		a2_glue_pkg::joy_digital_t res;
		sx = swap ? raw[7:0] : raw[15:8];
		sy = swap ? raw[15:8] : raw[7:0];
		res = dig;
		// A deflected axis kills its direction pair
		if (sy != 8'h00)
			res[3:2] = 2'b00;
		if (sx != 8'h00)
			res[1:0] = 2'b00;
		return res;
	endfunction

	// ==================================================
	// Check helpers
	// ==================================================

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		check_cnt++;
		assert (got == exp) else begin
			$display("FAILED %0t %s got %0h expected %0h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		check_cnt++;
		assert (cond) else begin
			$display("at %0t: %s", $time, what);
			err_cnt++;
		end
	endtask

	// Move to just after the next rising edge
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic finish_test(input string name);
		test_cnt++;
		$display("test %0d %s done, %0d errors", test_cnt, name, err_cnt - test_errs);
		test_errs = err_cnt;
	endtask

	// Joystick outputs show up two edges after their inputs
	always @(posedge clk_sys) begin
		#2;
		if (joy_stamp_q.size() > 0 && joy_stamp_q[0] + 2 == cycle_cnt) begin
			void'(joy_stamp_q.pop_front());
			exp_analog = joy_exp_analog_q.pop_front();
			exp_digital = joy_exp_digital_q.pop_front();
			check_value("joy_analog", 64'(joy_analog), 64'(exp_analog));
			check_value("joy_digital", 64'(joy_digital), 64'(exp_digital));
		end
	end

	// ==================================================
	// Tests
	// ==================================================

	task automatic run_joystick();
		logic [31:0] rnd;
		for (int i = 0; i < JOY_SAMPLES; i++) begin
			rnd = $random(seed);
			analog_swap = rnd[0];
			paddle_on_x = rnd[1];
			paddle_on_y = rnd[2];
			joy_digital_raw = rnd[8:3];
			paddle_raw = rnd[16:9];
			rnd = $random(seed);
			joy_analog_raw = rnd[15:0];
			// Centered axes now and then, so directions get through
			if (rnd[17:16] == 2'b00)
				joy_analog_raw[15:8] = 8'h00;
			if (rnd[19:18] == 2'b00)
				joy_analog_raw[7:0] = 8'h00;
			joy_stamp_q.push_back(cycle_cnt);
			joy_exp_analog_q.push_back(ref_joy_analog(analog_swap, paddle_on_x,
				paddle_on_y, paddle_raw, joy_analog_raw));
			joy_exp_digital_q.push_back(ref_joy_digital(analog_swap, joy_analog_raw,
				joy_digital_raw));
			step();
		end
		// Two samples still in flight
		while (joy_stamp_q.size() > 0)
			step();
	endtask

	task automatic check_ram_lanes(input a2_glue_pkg::ram_addr_t addr);
		if (aux_model.exists(int'(addr[15:0])))
			check_value("ram_dout[15:8]", 64'(ram_dout[15:8]), 64'(aux_model[int'(addr[15:0])]));
		if (main_model.exists(int'(addr)))
			check_value("ram_dout[7:0]", 64'(ram_dout[7:0]), 64'(main_model[int'(addr)]));
	endtask

	task automatic run_ram();
		logic [31:0]            rnd;
		a2_glue_pkg::ram_addr_t addr;
		for (int i = 0; i < RAM_ROUNDS; i++) begin
			rnd = $random(seed);
			// Three 64 KB regions, 64 offsets each, so reads hit known bytes
			addr = {(rnd[9:8] == 2'b11) ? 2'b10 : rnd[9:8], 10'b0, rnd[5:0]};
			ram_addr = addr;
			ram_din = rnd[23:16];
			ram_aux = rnd[24];
			ram_we = 1'b1;
			step();
			ram_we = 1'b0;
			if (rnd[24])
				aux_model[int'(addr[15:0])] = rnd[23:16];
			else
				main_model[int'(addr)] = rnd[23:16];
			// Written lane must already carry the new byte
			check_ram_lanes(addr);
			rnd = $random(seed);
			addr = {(rnd[9:8] == 2'b11) ? 2'b01 : rnd[9:8], 10'b0, rnd[5:0]};
			ram_addr = addr;
			step();
			check_ram_lanes(addr);
		end
	endtask

	// Host side of one transfer, entered on the cycle the request is high
	task automatic serve_transfer(input logic is_write, input logic inject_write);
		logic [31:0] rnd;
		int          delay;
		int          hold;
		rnd = $random(seed);
		delay = 1 + int'(rnd[2:0]);
		hold = 2 + int'(rnd[5:4]);
		repeat (delay) begin
			if (is_write)
				check_value("sd_wr", 64'(sd_wr), 64'd1);
			else
				check_value("sd_rd", 64'(sd_rd), 64'd1);
			check_value("cpu_wait", 64'(cpu_wait), 64'd1);
			step();
		end
		sd_ack = 1'b1;
		step();
		check_value("sd_rd", 64'(sd_rd), 64'd0);
		check_value("sd_wr", 64'(sd_wr), 64'd0);
		check_value("cpu_wait", 64'(cpu_wait), 64'd1);
		// Write pulse between ack rise and fall stays pending
		hdd_write = inject_write;
		step();
		hdd_write = 1'b0;
		repeat (hold) begin
			check_value("cpu_wait", 64'(cpu_wait), 64'd1);
			check_value("sd_wr", 64'(sd_wr), 64'd0);
			step();
		end
		sd_ack = 1'b0;
		step();
		check_value("cpu_wait", 64'(cpu_wait), 64'd0);
	endtask

	initial begin
		logic [31:0] rnd;
		int          waited;
		dd_reset = 1'b1;
		analog_swap = 1'b0;
		paddle_on_x = 1'b0;
		paddle_on_y = 1'b0;
		paddle_raw = '0;
		// Live stick values through reset, only the reset can zero the outputs
		joy_analog_raw = 16'h5a3c;
		joy_digital_raw = 6'h3f;
		hdd_read = 1'b0;
		hdd_write = 1'b0;
		hdd_lba_in = '0;
		sd_ack = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = '0;
		ram_addr = '0;
		ram_din = '0;
		ram_we = 1'b0;
		ram_aux = 1'b0;
		repeat (8) @(posedge clk_sys);
		#1;
		dd_reset = 1'b0;
		hdd_lba_in = 32'h0bad_5ec7;
		step();
		check_value("joy_analog", 64'(joy_analog), 64'd0);
		check_value("joy_digital", 64'(joy_digital), 64'd0);
		check_value("sd_rd", 64'(sd_rd), 64'd0);
		check_value("sd_wr", 64'(sd_wr), 64'd0);
		check_value("cpu_wait", 64'(cpu_wait), 64'd0);
		check_value("hdd_mounted", 64'(hdd_mounted), 64'd0);
		check_value("hdd_lba", 64'(hdd_lba), 64'h0bad_5ec7);
		finish_test("reset state");

		run_joystick();
		finish_test("joystick pipeline");

		run_ram();
		finish_test("ram banks");

		// Isolated read, sd_rd exactly two edges after the pulse
		hdd_read = 1'b1;
		step();
		hdd_read = 1'b0;
		check_value("sd_rd", 64'(sd_rd), 64'd0);
		step();
		check_value("sd_wr", 64'(sd_wr), 64'd0);
		serve_transfer(1'b0, 1'b0);
		finish_test("hdd read transfer");

		hdd_read = 1'b1;
		step();
		hdd_read = 1'b0;
		step();
		serve_transfer(1'b0, 1'b1);
		waited = 0;
		while (!sd_wr && waited < 8) begin
			step();
			waited++;
		end
		check_true(sd_wr, "queued write never started a transfer");
		check_value("sd_rd", 64'(sd_rd), 64'd0);
		serve_transfer(1'b1, 1'b0);
		finish_test("hdd queued write");

		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			img_size = i[0] ? ({rnd, 32'd0} | 64'd512) : 64'd0;
			img_readonly = i[1];
			img_mounted = 1'b1;
			step();
			img_mounted = 1'b0;
			check_value("hdd_mounted", 64'(hdd_mounted), 64'(i[0]));
			check_value("hdd_protect", 64'(hdd_protect), 64'(i[1]));
		end
		finish_test("mount capture");

		// Sequencer properties count as errors too
		err_cnt += uut.u_hdd_seq.u_checker.assert_fails;
		$display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES)
			@(posedge clk_sys);
		$display("timeout after %0d cycles, the run did not finish", cycle_cnt);
		$display("TESTS FAILED");
		$finish;
	end

endmodule
